//--- sources.f
+incdir+hw
hw/tx_pkg.sv
hw/tx_desc_ram.sv
hw/tx_desc_fetch.sv
hw/tx_data_ring.sv
hw/tx_dma_split.sv
hw/tx_writeback.sv
hw/tx_engine_top.sv
testbench/tb_tx_responders.sv
testbench/tb_tx_engine.sv

//--- Bender.yml
package:
  name: tx_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/tx_pkg.sv
      - hw/tx_desc_ram.sv
      - hw/tx_desc_fetch.sv
      - hw/tx_data_ring.sv
      - hw/tx_dma_split.sv
      - hw/tx_writeback.sv
      - hw/tx_engine_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_tx_responders.sv
      - testbench/tb_tx_engine.sv

//--- testbench/tb_tx_engine.sv
`timescale 1ns/1ps
`include "tx_defs.svh"

module tb_tx_engine;

	// Twice the summed worst case of the five tests
	localparam int TIMEOUT_CYCLES = 2 * (100 + 150 + 100 + 150 + 1500);

	logic aclk = 1'b0;
	logic aresetn;
	logic stall_en;
	logic [31:0] cmd_s_tdata;
	logic cmd_s_tvalid;
	logic cmd_s_tlast;
	logic cmd_s_tready;
	logic [31:0] stat_m_tdata;
	logic stat_m_tvalid;
	logic stat_m_tlast;
	logic stat_m_tready;
	logic [31:0] idma_m_tdata;
	logic idma_m_tvalid;
	logic idma_m_tlast;
	logic idma_m_tready;
	logic [31:0] idma_s_tdata;
	logic idma_s_tvalid;
	logic idma_s_tlast;
	logic idma_s_tready;
	logic [31:0] frm_m_tdata;
	logic frm_m_tvalid;
	logic frm_m_tlast;
	logic frm_m_tready;
	logic [31:0] frm_s_tdata;
	logic frm_s_tvalid;
	logic frm_s_tlast;
	logic frm_s_tready;
	logic host_we;
	logic [`TX_DESC_AW-1:0] host_addr;
	logic [31:0] host_wdata;
	logic [31:0] host_rdata;

	int cycles = 0;
	int exp_tail = 0;
	int ring_head = 0;
	int ring_tail = 0;
	int idma_beat = 0;
	int idma_cmds = 0;
	logic [31:0] rnd;

	tx_engine_top uut (.*);

	tb_tx_responders rsp (.*);

	always #50 aclk = ~aclk;

	always @(posedge aclk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	always @(posedge aclk) begin
		rnd = rsp.next_random();
		stat_m_tready <= stall_en ? rnd[20] : 1'b1;
	end

	// Ring space model with free as head - tail - 1 modulo the ring size
	always @(posedge aclk) begin
		int dw;
		int free;
		if (frm_s_tvalid && frm_s_tready && frm_s_tlast)
			ring_head = ((frm_s_tdata[15:0] + frm_s_tdata[31:16] + 3) >> 2) % `TX_DATA_RAM_DWORDS;
		if (idma_m_tvalid && idma_m_tready) begin
			if (idma_beat == 0) begin
				dw = idma_m_tdata[27:16] >> 2;
				free = (ring_head - ring_tail - 1 + `TX_DATA_RAM_DWORDS) % `TX_DATA_RAM_DWORDS;
				if (dw > free) begin
					$display("iDMA command of %0d dwords exceeds %0d free dwords", dw, free);
					$display("SIMULATION FAILED");
					$fatal(1);
				end
				ring_tail = (ring_tail + dw) % `TX_DATA_RAM_DWORDS;
				idma_cmds++;
			end
			idma_beat = idma_m_tlast ? 0 : idma_beat + 1;
		end
	end

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s got %08h expected %08h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_hi(input string what, input tx_pkg::desc_hi_u got,
		input tx_pkg::desc_hi_u exp);
		if (got !== exp) begin
			$display("ERR %0t: %s got %016h expected %016h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_ram(input int addr, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: RAM word %0d got %08h expected %08h", $time, addr, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic load_desc(input int slot, input logic [63:0] buf_addr,
		input tx_pkg::desc_hi_u hi);
		logic [31:0] words [4];
		words[0] = buf_addr[31:0];
		words[1] = buf_addr[63:32];
		words[2] = hi[31:0];
		words[3] = hi[63:32];
		for (int i = 0; i < 4; i++) begin
			@(posedge aclk);
			host_we <= 1'b1;
			host_addr <= `TX_DESC_AW'(slot * 4 + i);
			host_wdata <= words[i];
		end
		@(posedge aclk);
		host_we <= 1'b0;
	endtask

	task automatic read_ram(input int addr, output logic [31:0] data);
		@(posedge aclk);
		host_addr <= `TX_DESC_AW'(addr);
		@(posedge aclk);
		@(posedge aclk);
		data = host_rdata;
	endtask

	task automatic send_cmd(input int slot);
		@(posedge aclk);
		cmd_s_tdata <= 32'(slot * 16);
		cmd_s_tvalid <= 1'b1;
		cmd_s_tlast <= 1'b1;
		do
			@(posedge aclk);
		while (!cmd_s_tready);
		cmd_s_tvalid <= 1'b0;
	endtask

	task automatic wait_status(output logic [31:0] data);
		do
			@(posedge aclk);
		while (!(stat_m_tvalid && stat_m_tready));
		if (stat_m_tlast !== 1'b1)
			report_failure("Status beat arrived without tlast");
		data = stat_m_tdata;
	endtask

	task automatic check_chunk(input int dwords, input logic [63:0] host);
		if (rsp.idma_q.size() < 3)
			report_failure("Missing iDMA command beats");
		check_word("iDMA beat 1", rsp.idma_q.pop_front(),
			{4'b0, 12'(dwords * 4), 16'(exp_tail * 4)});
		check_word("iDMA beat 2", rsp.idma_q.pop_front(), host[31:0]);
		check_word("iDMA beat 3", rsp.idma_q.pop_front(), host[63:32]);
		exp_tail = (exp_tail + dwords) % `TX_DATA_RAM_DWORDS;
	endtask

	task automatic check_frame(input logic [15:0] start, input tx_pkg::desc_hi_u hi);
		tx_pkg::desc_hi_u got;
		if (rsp.frm_q.size() < 3)
			report_failure("Missing frame command beats");
		check_word("frame beat 1", rsp.frm_q.pop_front(), {hi.legacy.length, start});
		got[31:0] = rsp.frm_q.pop_front();
		got[63:32] = rsp.frm_q.pop_front();
		check_hi("frame beats 2 and 3", got, hi);
	endtask

	function automatic tx_pkg::desc_hi_u make_hi(input logic [15:0] len, input logic [7:0] cmd);
		tx_pkg::desc_hi_u hi;
		hi.legacy.length = len;
		hi.legacy.cso = 8'h11;
		hi.legacy.cmd = cmd;
		hi.legacy.sta = 4'h0;
		hi.legacy.reserved = 4'h0;
		hi.legacy.css = 8'h22;
		hi.legacy.special = 16'hbeef;
		return hi;
	endfunction

	// Status word with IDE in bit 17 and RS in bit 16
	function automatic logic [31:0] status_of(input int slot, input logic rs, input logic ide);
		logic [31:0] word;
		word = 32'(slot * 16);
		word[16] = rs;
		word[17] = ide;
		return word;
	endfunction

	// Legacy 100-byte buffer at offset 2 with RS and IDE
	task automatic test_single_chunk();
		tx_pkg::desc_hi_u hi;
		tx_pkg::desc_hi_u exp_wb;
		logic [31:0] data;
		logic [15:0] start;
		hi = make_hi(16'd100, 8'h88);
		load_desc(0, 64'h0000_0001_0000_1002, hi);
		start = 16'(exp_tail * 4 + 2);
		send_cmd(0);
		wait_status(data);
		check_word("status", data, status_of(0, 1'b1, 1'b1));
		check_chunk(26, 64'h0000_0001_0000_1000);
		check_frame(start, hi);
		exp_wb = hi;
		exp_wb.legacy.sta = 4'b0001;
		read_ram(3, data);
		check_ram(3, data, exp_wb[63:32]);
		rsp.release_frame();
	endtask

	task automatic test_two_chunks();
		tx_pkg::desc_hi_u hi;
		logic [31:0] data;
		logic [15:0] start;
		hi = make_hi(16'd1500, 8'h08);
		load_desc(1, 64'h0000_0000_2000_0000, hi);
		start = 16'(exp_tail * 4);
		send_cmd(1);
		wait_status(data);
		check_word("status", data, status_of(1, 1'b1, 1'b0));
		check_chunk(256, 64'h0000_0000_2000_0000);
		check_chunk(119, 64'h0000_0000_2000_0400);
		check_frame(start, hi);
		rsp.release_frame();
	endtask

	task automatic test_no_rs();
		tx_pkg::desc_hi_u hi;
		logic [31:0] data;
		logic [15:0] start;
		hi = make_hi(16'd64, 8'h00);
		load_desc(2, 64'h0000_0000_0000_4000, hi);
		start = 16'(exp_tail * 4);
		send_cmd(2);
		wait_status(data);
		check_word("status", data, status_of(2, 1'b0, 1'b0));
		check_chunk(16, 64'h0000_0000_0000_4000);
		check_frame(start, hi);
		read_ram(11, data);
		check_ram(11, data, hi[63:32]);
		rsp.release_frame();
	endtask

	// DEXT, zero length and null buffer skip the data phase
	task automatic test_skips();
		tx_pkg::desc_hi_u hi [3];
		logic [63:0] bufs [3];
		logic [31:0] data;
		hi[0] = make_hi(16'd200, 8'h28);
		hi[1] = make_hi(16'd0, 8'h08);
		hi[2] = make_hi(16'd200, 8'h08);
		bufs[0] = 64'h0000_0000_0000_5000;
		bufs[1] = 64'h0000_0000_0000_6000;
		bufs[2] = 64'd0;
		for (int i = 0; i < 3; i++) begin
			load_desc(3 + i, bufs[i], hi[i]);
			send_cmd(3 + i);
			wait_status(data);
			check_word("status", data, status_of(3 + i, 1'b1, 1'b0));
		end
		repeat (10) @(posedge aclk);
		if (rsp.idma_q.size() != 0 || rsp.frm_q.size() != 0)
			report_failure("A skipped descriptor produced iDMA or frame beats");
	endtask

	task automatic test_ring_backpressure();
		tx_pkg::desc_hi_u hi;
		int base;
		hi = make_hi(16'd1500, 8'h08);
		for (int i = 0; i < 5; i++)
			load_desc(8 + i, 64'h3000_0000 + 64'(i * 32'h1000), hi);
		base = idma_cmds;
		stall_en <= 1'b1;
		fork
			for (int i = 0; i < 5; i++)
				send_cmd(8 + i);
			begin
				logic [31:0] data;
				for (int i = 0; i < 5; i++) begin
					wait_status(data);
					check_word("ordered status", data, status_of(8 + i, 1'b1, 1'b0));
				end
			end
			begin
				// Two whole descriptors fit and then only the first chunk of the third
				repeat (200) @(posedge aclk);
				if (idma_cmds - base != 5)
					report_failure("Wrong iDMA command count while the ring is full");
				for (int i = 0; i < 5; i++)
					rsp.release_frame();
			end
		join
		if (idma_cmds - base != 10)
			report_failure("iDMA issuing did not resume after frame release");
		stall_en <= 1'b0;
		rsp.idma_q.delete();
		rsp.frm_q.delete();
	endtask

	initial begin
		aresetn = 1'b0;
		stall_en = 1'b0;
		cmd_s_tdata = 32'd0;
		cmd_s_tvalid = 1'b0;
		cmd_s_tlast = 1'b0;
		stat_m_tready = 1'b1;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = 32'd0;
		repeat (4) @(posedge aclk);
		aresetn <= 1'b1;
		test_single_chunk();
		test_two_chunks();
		test_no_rs();
		test_skips();
		test_ring_backpressure();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- testbench/tb_tx_responders.sv
`timescale 1ns/1ps

module tb_tx_responders (
	input logic aclk,
	input logic stall_en,

	input logic [31:0] idma_m_tdata,
	input logic idma_m_tvalid,
	input logic idma_m_tlast,
	output logic idma_m_tready,
	output logic [31:0] idma_s_tdata,
	output logic idma_s_tvalid,
	output logic idma_s_tlast,
	input logic idma_s_tready,

	input logic [31:0] frm_m_tdata,
	input logic frm_m_tvalid,
	input logic frm_m_tlast,
	output logic frm_m_tready,
	output logic [31:0] frm_s_tdata,
	output logic frm_s_tvalid,
	output logic frm_s_tlast,
	input logic frm_s_tready
);

	logic [31:0] idma_q[$];
	logic [31:0] frm_q[$];
	// Beat 1 of every frame that still waits for its response
	logic [31:0] pend_q[$];
	logic [31:0] rng_state = 32'd12959;
	int resp_cnt;
	int frm_beat;
	logic [31:0] rnd;

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	initial begin
		idma_m_tready = 1'b1;
		idma_s_tdata = 32'd0;
		idma_s_tvalid = 1'b0;
		idma_s_tlast = 1'b0;
		frm_m_tready = 1'b1;
		frm_s_tdata = 32'd0;
		frm_s_tvalid = 1'b0;
		frm_s_tlast = 1'b0;
		resp_cnt = 0;
		frm_beat = 0;
	end

	// iDMA model, answers each command after a short random delay
	always @(posedge aclk) begin
		rnd = next_random();
		idma_m_tready <= stall_en ? rnd[16] : 1'b1;
		if (idma_s_tvalid && idma_s_tready)
			idma_s_tvalid <= 1'b0;
		if (idma_m_tvalid && idma_m_tready) begin
			idma_q.push_back(idma_m_tdata);
			if (idma_m_tlast)
				resp_cnt <= 1 + int'(rnd[9:8]);
		end else if (resp_cnt > 1) begin
			resp_cnt <= resp_cnt - 1;
		end else if (resp_cnt == 1) begin
			idma_s_tvalid <= 1'b1;
			idma_s_tlast <= 1'b1;
			idma_s_tdata <= 32'd0;
			resp_cnt <= 0;
		end
	end

	// Frame processor capture
	always @(posedge aclk) begin
		if (frm_m_tvalid && frm_m_tready) begin
			frm_q.push_back(frm_m_tdata);
			if (frm_beat == 0)
				pend_q.push_back(frm_m_tdata);
			frm_beat <= frm_m_tlast ? 0 : frm_beat + 1;
		end
	end

	task automatic release_frame();
		while (pend_q.size() == 0)
			@(posedge aclk);
		@(posedge aclk);
		frm_s_tdata <= pend_q.pop_front();
		frm_s_tvalid <= 1'b1;
		frm_s_tlast <= 1'b1;
		do
			@(posedge aclk);
		while (!frm_s_tready);
		frm_s_tvalid <= 1'b0;
		frm_s_tlast <= 1'b0;
	endtask

endmodule

//--- hw/tx_engine_top.sv
`timescale 1ns/1ps
`include "tx_defs.svh"

module tx_engine_top (
	input logic aclk,
	input logic aresetn,

	input logic [31:0] cmd_s_tdata,
	input logic cmd_s_tvalid,
	input logic cmd_s_tlast,
	output logic cmd_s_tready,

	output logic [31:0] stat_m_tdata,
	output logic stat_m_tvalid,
	output logic stat_m_tlast,
	input logic stat_m_tready,

	output logic [31:0] idma_m_tdata,
	output logic idma_m_tvalid,
	output logic idma_m_tlast,
	input logic idma_m_tready,

	input logic [31:0] idma_s_tdata,
	input logic idma_s_tvalid,
	input logic idma_s_tlast,
	output logic idma_s_tready,

	output logic [31:0] frm_m_tdata,
	output logic frm_m_tvalid,
	output logic frm_m_tlast,
	input logic frm_m_tready,

	input logic [31:0] frm_s_tdata,
	input logic frm_s_tvalid,
	input logic frm_s_tlast,
	output logic frm_s_tready,

	input logic host_we,
	input logic [`TX_DESC_AW-1:0] host_addr,
	input logic [31:0] host_wdata,
	output logic [31:0] host_rdata
);

	logic rd_en;
	logic [`TX_DESC_AW-1:0] rd_addr;
	logic [31:0] rd_data;
	logic wb_we;
	logic [`TX_DESC_AW-1:0] wb_addr;
	logic [31:0] wb_wdata;
	logic wb_ready;

	logic fd_valid;
	logic fd_ready;
	logic [15:0] fd_addr;
	logic [63:0] fd_buf_addr;
	tx_pkg::desc_hi_u fd_hi;

	logic sw_valid;
	logic sw_ready;
	logic [15:0] sw_addr;
	tx_pkg::desc_hi_u sw_hi;

	logic chunk_take;
	logic [`TX_CHUNK_W-1:0] chunk_dwords;
	logic [`TX_RING_AW-1:0] tail;
	logic [`TX_RING_AW-1:0] free_dwords;

	tx_desc_ram u_ram (
		.aclk(aclk),
		.host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_rdata(host_rdata),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.wb_we(wb_we), .wb_addr(wb_addr), .wb_wdata(wb_wdata), .wb_ready(wb_ready)
	);

	tx_desc_fetch u_fetch (
		.aclk(aclk), .aresetn(aresetn),
		.cmd_s_tdata(cmd_s_tdata), .cmd_s_tvalid(cmd_s_tvalid),
		.cmd_s_tlast(cmd_s_tlast), .cmd_s_tready(cmd_s_tready),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.fd_valid(fd_valid), .fd_addr(fd_addr), .fd_buf_addr(fd_buf_addr),
		.fd_hi(fd_hi), .fd_ready(fd_ready)
	);

	tx_data_ring u_ring (
		.aclk(aclk), .aresetn(aresetn),
		.chunk_take(chunk_take), .chunk_dwords(chunk_dwords),
		.frm_s_tdata(frm_s_tdata), .frm_s_tvalid(frm_s_tvalid),
		.frm_s_tlast(frm_s_tlast), .frm_s_tready(frm_s_tready),
		.tail(tail), .free_dwords(free_dwords)
	);

	tx_dma_split u_split (
		.aclk(aclk), .aresetn(aresetn),
		.fd_valid(fd_valid), .fd_addr(fd_addr), .fd_buf_addr(fd_buf_addr),
		.fd_hi(fd_hi), .fd_ready(fd_ready),
		.tail(tail), .free_dwords(free_dwords),
		.chunk_take(chunk_take), .chunk_dwords(chunk_dwords),
		.idma_m_tdata(idma_m_tdata), .idma_m_tvalid(idma_m_tvalid),
		.idma_m_tlast(idma_m_tlast), .idma_m_tready(idma_m_tready),
		.idma_s_tdata(idma_s_tdata), .idma_s_tvalid(idma_s_tvalid),
		.idma_s_tlast(idma_s_tlast), .idma_s_tready(idma_s_tready),
		.frm_m_tdata(frm_m_tdata), .frm_m_tvalid(frm_m_tvalid),
		.frm_m_tlast(frm_m_tlast), .frm_m_tready(frm_m_tready),
		.sw_valid(sw_valid), .sw_addr(sw_addr), .sw_hi(sw_hi), .sw_ready(sw_ready)
	);

	tx_writeback u_wb (
		.aclk(aclk), .aresetn(aresetn),
		.sw_valid(sw_valid), .sw_addr(sw_addr), .sw_hi(sw_hi), .sw_ready(sw_ready),
		.wb_we(wb_we), .wb_addr(wb_addr), .wb_wdata(wb_wdata), .wb_ready(wb_ready),
		.stat_m_tdata(stat_m_tdata), .stat_m_tvalid(stat_m_tvalid),
		.stat_m_tlast(stat_m_tlast), .stat_m_tready(stat_m_tready)
	);

endmodule

//--- hw/tx_writeback.sv
`timescale 1ns/1ps
`include "tx_defs.svh"

module tx_writeback (
	input logic aclk,
	input logic aresetn,

	// From split stage
	input logic sw_valid,
	input logic [15:0] sw_addr,
	input tx_pkg::desc_hi_u sw_hi,
	output logic sw_ready,

	// Descriptor RAM write-back
	output logic wb_we,
	output logic [`TX_DESC_AW-1:0] wb_addr,
	output logic [31:0] wb_wdata,
	input logic wb_ready,

	// Status, [17] IDE, [16] RS, [15:0] descriptor address
	output logic [31:0] stat_m_tdata,
	output logic stat_m_tvalid,
	output logic stat_m_tlast,
	input logic stat_m_tready
);

	typedef enum logic [1:0] {S_IDLE, S_WRITE, S_REPORT} state_t;

	state_t state;
	logic [15:0] desc_addr;
	tx_pkg::desc_hi_u desc_hi;
	logic sw_take;

	assign sw_ready = (state == S_IDLE);
	assign sw_take = sw_valid && sw_ready;

	assign wb_we = (state == S_WRITE);
	assign wb_addr = {desc_addr[`TX_DESC_AW+1:4], `TX_WB_WORD};
	// STA becomes DD only, rest of word 3 kept
	assign wb_wdata = {desc_hi.legacy.special, desc_hi.legacy.css,
		desc_hi.legacy.reserved, 4'b0001};

	assign stat_m_tvalid = (state == S_REPORT);
	assign stat_m_tlast = 1'b1;
	assign stat_m_tdata = {14'd0, desc_hi.legacy.cmd[`TX_CMD_IDE],
		desc_hi.legacy.cmd[`TX_CMD_RS], desc_addr};

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (sw_take)
						state <= sw_hi.legacy.cmd[`TX_CMD_RS] ? S_WRITE : S_REPORT;
				end
				// Wait for a cycle without a host write
				S_WRITE: if (wb_ready) state <= S_REPORT;
				S_REPORT: if (stat_m_tready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (sw_take) begin
			desc_addr <= sw_addr;
			desc_hi <= sw_hi;
		end
	end

endmodule

//--- hw/tx_dma_split.sv
`timescale 1ns/1ps
`include "tx_defs.svh"

module tx_dma_split (
	input logic aclk,
	input logic aresetn,

	// From fetch stage
	input logic fd_valid,
	input logic [15:0] fd_addr,
	input logic [63:0] fd_buf_addr,
	input tx_pkg::desc_hi_u fd_hi,
	output logic fd_ready,

	// Data RAM ring
	input logic [`TX_RING_AW-1:0] tail,
	input logic [`TX_RING_AW-1:0] free_dwords,
	output logic chunk_take,
	output logic [`TX_CHUNK_W-1:0] chunk_dwords,

	// iDMA command and response
	output logic [31:0] idma_m_tdata,
	output logic idma_m_tvalid,
	output logic idma_m_tlast,
	input logic idma_m_tready,
	input logic [31:0] idma_s_tdata,
	input logic idma_s_tvalid,
	input logic idma_s_tlast,
	output logic idma_s_tready,

	// Frame processor command
	output logic [31:0] frm_m_tdata,
	output logic frm_m_tvalid,
	output logic frm_m_tlast,
	input logic frm_m_tready,

	// To write-back stage
	output logic sw_valid,
	output logic [15:0] sw_addr,
	output tx_pkg::desc_hi_u sw_hi,
	input logic sw_ready
);

	typedef enum logic [3:0] {
		S_IDLE, S_SPACE, S_DMA1, S_DMA2, S_DMA3, S_RESP,
		S_FRM1, S_FRM2, S_FRM3, S_PASS
	} state_t;

	state_t state;
	logic [63:0] host_addr;
	logic [15:0] remain;
	logic [`TX_CHUNK_W-1:0] cur_chunk;
	logic [15:0] local_start;
	logic [16:0] span_bytes;
	logic [14:0] span_dwords;
	logic skip;
	logic fd_take;
	logic rsp_take;
	logic last_chunk;

	assign fd_ready = (state == S_IDLE);
	assign fd_take = fd_valid && fd_ready;
	assign idma_s_tready = 1'b1;
	assign rsp_take = (state == S_RESP) && idma_s_tvalid && idma_s_tlast;
	assign last_chunk = (remain == 16'(cur_chunk));
	assign sw_valid = (state == S_PASS);

	// No data phase for DEXT, empty or null buffers
	assign skip = fd_hi.ext.dcmd[`TX_CMD_DEXT] || (fd_hi.legacy.length == 16'd0) ||
		(fd_buf_addr == 64'd0);

	// Buffer bytes plus leading offset, in dwords rounded up
	assign span_bytes = {1'b0, fd_hi.legacy.length} + 17'(fd_buf_addr[1:0]);
	assign span_dwords = span_bytes[16:2] + 15'(|span_bytes[1:0]);

	assign chunk_dwords = (remain > 16'(`TX_MAX_CHUNK_DWORDS)) ?
		`TX_CHUNK_W'(`TX_MAX_CHUNK_DWORDS) : remain[`TX_CHUNK_W-1:0];
	assign chunk_take = (state == S_SPACE) && (free_dwords >= `TX_RING_AW'(chunk_dwords));

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= S_IDLE;
			idma_m_tvalid <= 1'b0;
			idma_m_tlast <= 1'b0;
			frm_m_tvalid <= 1'b0;
			frm_m_tlast <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (fd_take) state <= skip ? S_PASS : S_SPACE;
				S_SPACE: begin
					if (chunk_take) begin
						state <= S_DMA1;
						idma_m_tvalid <= 1'b1;
					end
				end
				S_DMA1: if (idma_m_tready) state <= S_DMA2;
				S_DMA2: begin
					if (idma_m_tready) begin
						state <= S_DMA3;
						idma_m_tlast <= 1'b1;
					end
				end
				S_DMA3: begin
					if (idma_m_tready) begin
						state <= S_RESP;
						idma_m_tvalid <= 1'b0;
						idma_m_tlast <= 1'b0;
					end
				end
				S_RESP: begin
					if (rsp_take) begin
						if (last_chunk) begin
							state <= S_FRM1;
							frm_m_tvalid <= 1'b1;
						end else begin
							state <= S_SPACE;
						end
					end
				end
				S_FRM1: if (frm_m_tready) state <= S_FRM2;
				S_FRM2: begin
					if (frm_m_tready) begin
						state <= S_FRM3;
						frm_m_tlast <= 1'b1;
					end
				end
				S_FRM3: begin
					if (frm_m_tready) begin
						state <= S_PASS;
						frm_m_tvalid <= 1'b0;
						frm_m_tlast <= 1'b0;
					end
				end
				S_PASS: if (sw_ready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (fd_take) begin
			sw_addr <= fd_addr;
			sw_hi <= fd_hi;
			host_addr <= {fd_buf_addr[63:2], 2'b00};
			remain <= 16'(span_dwords);
			// Tail here is where the first chunk lands
			local_start <= 16'({tail, fd_buf_addr[1:0]});
		end
		if (chunk_take) begin
			cur_chunk <= chunk_dwords;
			idma_m_tdata <= {4'b0000, 12'({chunk_dwords, 2'b00}), 16'({tail, 2'b00})};
		end
		if (idma_m_tvalid && idma_m_tready) begin
			if (state == S_DMA1)
				idma_m_tdata <= host_addr[31:0];
			else if (state == S_DMA2)
				idma_m_tdata <= host_addr[63:32];
		end
		if (rsp_take) begin
			remain <= remain - 16'(cur_chunk);
			host_addr <= host_addr + 64'({cur_chunk, 2'b00});
			if (last_chunk)
				frm_m_tdata <= {sw_hi.legacy.length, local_start};
		end
		if (frm_m_tvalid && frm_m_tready) begin
			if (state == S_FRM1)
				frm_m_tdata <= sw_hi[31:0];
			else if (state == S_FRM2)
				frm_m_tdata <= sw_hi[63:32];
		end
	end

endmodule

//--- hw/tx_data_ring.sv
`timescale 1ns/1ps
`include "tx_defs.svh"

module tx_data_ring (
	input logic aclk,
	input logic aresetn,

	// Space claimed by the split stage
	input logic chunk_take,
	input logic [`TX_CHUNK_W-1:0] chunk_dwords,

	// Frame response, [31:16] length, [15:0] start byte
	input logic [31:0] frm_s_tdata,
	input logic frm_s_tvalid,
	input logic frm_s_tlast,
	output logic frm_s_tready,

	output logic [`TX_RING_AW-1:0] tail,
	output logic [`TX_RING_AW-1:0] free_dwords
);

	logic [`TX_RING_AW-1:0] head;
	logic [`TX_RING_AW-1:0] head_next;
	logic [`TX_RING_AW-1:0] tail_next;
	logic [15:0] frm_end;

	assign frm_s_tready = 1'b1;
	assign frm_end = frm_s_tdata[15:0] + frm_s_tdata[31:16];

	always_comb begin
		head_next = head;
		// Frame done, free up to its last dword rounded up
		if (frm_s_tvalid && frm_s_tready && frm_s_tlast)
			head_next = frm_end[`TX_RING_AW+1:2] + `TX_RING_AW'(|frm_end[1:0]);
		tail_next = tail;
		if (chunk_take)
			tail_next = tail + `TX_RING_AW'(chunk_dwords);
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			head <= '0;
			tail <= '0;
			free_dwords <= `TX_RING_AW'(`TX_DATA_RAM_DWORDS - 1);
		end else begin
			head <= head_next;
			tail <= tail_next;
			// One slot kept empty so head == tail means empty
			free_dwords <= head_next - tail_next - `TX_RING_AW'(1);
		end
	end

endmodule

//--- hw/tx_desc_fetch.sv
`timescale 1ns/1ps
`include "tx_defs.svh"

module tx_desc_fetch (
	input logic aclk,
	input logic aresetn,

	// Command, descriptor byte address in [15:0]
	input logic [31:0] cmd_s_tdata,
	input logic cmd_s_tvalid,
	input logic cmd_s_tlast,
	output logic cmd_s_tready,

	// Descriptor RAM read
	output logic rd_en,
	output logic [`TX_DESC_AW-1:0] rd_addr,
	input logic [31:0] rd_data,

	// To split stage
	output logic fd_valid,
	output logic [15:0] fd_addr,
	output logic [63:0] fd_buf_addr,
	output tx_pkg::desc_hi_u fd_hi,
	input logic fd_ready
);

	logic rd_busy;
	logic [1:0] rd_cnt;
	logic ld_en;
	logic [1:0] ld_idx;
	logic cmd_take;

	// Busy from first read until split takes the descriptor
	assign cmd_s_tready = !(rd_busy || ld_en || fd_valid);
	assign cmd_take = cmd_s_tvalid && cmd_s_tready && cmd_s_tlast;

	assign rd_en = rd_busy;
	assign rd_addr = {fd_addr[`TX_DESC_AW+1:4], rd_cnt};

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			rd_busy <= 1'b0;
			rd_cnt <= 2'd0;
			ld_en <= 1'b0;
			ld_idx <= 2'd0;
			fd_valid <= 1'b0;
		end else begin
			if (cmd_take) begin
				rd_busy <= 1'b1;
				rd_cnt <= 2'd0;
			end else if (rd_busy) begin
				rd_cnt <= rd_cnt + 2'd1;
				if (rd_cnt == 2'd3)
					rd_busy <= 1'b0;
			end

			// RAM data lags the read by one cycle
			ld_en <= rd_busy;
			ld_idx <= rd_cnt;

			if (ld_en && ld_idx == 2'd3)
				fd_valid <= 1'b1;
			else if (fd_valid && fd_ready)
				fd_valid <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (cmd_take)
			fd_addr <= cmd_s_tdata[15:0];
		if (ld_en) begin
			case (ld_idx)
				2'd0: fd_buf_addr[31:0] <= rd_data;
				2'd1: fd_buf_addr[63:32] <= rd_data;
				2'd2: fd_hi[31:0] <= rd_data;
				default: fd_hi[63:32] <= rd_data;
			endcase
		end
	end

endmodule

//--- hw/tx_desc_ram.sv
`timescale 1ns/1ps
`include "tx_defs.svh"

module tx_desc_ram (
	input logic aclk,

	// Host side
	input logic host_we,
	input logic [`TX_DESC_AW-1:0] host_addr,
	input logic [31:0] host_wdata,
	output logic [31:0] host_rdata,

	// Engine fetch
	input logic rd_en,
	input logic [`TX_DESC_AW-1:0] rd_addr,
	output logic [31:0] rd_data,

	// Engine write-back
	input logic wb_we,
	input logic [`TX_DESC_AW-1:0] wb_addr,
	input logic [31:0] wb_wdata,
	output logic wb_ready
);

	logic [31:0] mem [`TX_DESC_RAM_WORDS];

	// Host write has priority on the shared write port
	assign wb_ready = !host_we;

	always_ff @(posedge aclk) begin
		if (host_we)
			mem[host_addr] <= host_wdata;
		else if (wb_we)
			mem[wb_addr] <= wb_wdata;
	end

	always_ff @(posedge aclk) begin
		host_rdata <= mem[host_addr];
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

//--- hw/tx_pkg.sv
package tx_pkg;

	// Legacy data descriptor, word 3 in the upper half
	typedef struct packed {
		logic [15:0] special;
		logic [7:0] css;
		logic [3:0] reserved;
		logic [3:0] sta;
		logic [7:0] cmd;
		logic [7:0] cso;
		logic [15:0] length;
	} legacy_hi_t;

	// Extended data descriptor
	typedef struct packed {
		// MSS for TSO, VLAN otherwise
		logic [15:0] mss;
		logic [7:0] ports;
		logic [3:0] reserved;
		logic [3:0] sta;
		// Same byte as legacy cmd
		logic [7:0] dcmd;
		logic [3:0] dtyp;
		logic [19:0] paylen;
	} ext_hi_t;

	// Words 2 and 3 in either reading
	typedef union packed {
		legacy_hi_t legacy;
		ext_hi_t ext;
	} desc_hi_u;

endpackage

//--- hw/tx_defs.svh
`ifndef TX_DEFS_SVH
`define TX_DEFS_SVH

// Descriptor RAM depth in 32-bit words
`define TX_DESC_RAM_WORDS 256
`define TX_DESC_AW ($clog2(`TX_DESC_RAM_WORDS))

// Data RAM ring in dwords, power of two
`define TX_DATA_RAM_DWORDS 1024
`define TX_RING_AW ($clog2(`TX_DATA_RAM_DWORDS))

// Largest single iDMA read
`define TX_MAX_CHUNK_DWORDS 256
`define TX_CHUNK_W ($clog2(`TX_MAX_CHUNK_DWORDS) + 1)

// Flag positions in the command byte
`define TX_CMD_RS 3
`define TX_CMD_DEXT 5
`define TX_CMD_IDE 7

// Descriptor word that carries STA
`define TX_WB_WORD 2'd3

`endif
